//--- verilog.f
+incdir+testbench
design/store_buffer_pkg.sv
design/spec_store_queue.sv
design/commit_store_queue.sv
design/page_offset_checker.sv
design/store_buffer.sv
testbench/tb_store_buffer.sv

//--- run_verilator.sh
#!/bin/sh
# builds the store buffer testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --timescale 1ns/1ps -f verilog.f \
    --top-module tb_store_buffer -Mdir "$BUILD_DIR" -o tb_store_buffer
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$BUILD_DIR/tb_store_buffer" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "test passed" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1

//--- testbench/tb_store_model.svh
// reference model of both store queues, output prediction and the cache request compare
`ifndef TB_STORE_MODEL_SVH
`define TB_STORE_MODEL_SVH

// one store is kept as {addr, data, be, size}
localparam int ENTRY_W = ADDR_W + DATA_W + BE_W + SIZE_W;

// oldest store at index 0 in both lists
logic [ENTRY_W-1:0] spec_q[$];
logic [ENTRY_W-1:0] commit_q[$];
// commits applied to the model and requests that the DUT handed to the cache
// every commit must come back out as exactly one retirement
int committed_cnt;
int retired_cnt;

function automatic logic [ADDR_W-1:0] entry_addr(input logic [ENTRY_W-1:0] e);
    return e[ENTRY_W-1 -: ADDR_W];
endfunction

task automatic model_reset();
    spec_q.delete();
    commit_q.delete();
    committed_cnt = 0;
    retired_cnt   = 0;
endtask

// at each rising edge a grant retires the commit head, then flush or commit and push apply
task automatic model_edge(input logic push, input logic com, input logic fl, input logic gnt,
                          input logic [ENTRY_W-1:0] entry);
    if (gnt && commit_q.size() > 0) begin
        void'(commit_q.pop_front());
    end
    // a flush drops the store offered in the same cycle as well
    if (fl) begin
        spec_q.delete();
    end else begin
        if (com) begin
            commit_q.push_back(spec_q.pop_front());
            committed_cnt++;
        end
        if (push) begin
            spec_q.push_back(entry);
        end
    end
endtask

// keeps one slot of slack unless the head leaves in this cycle
function automatic logic exp_ready(input logic com);
    return (spec_q.size() < SPEC_DEPTH - 1) || com;
endfunction

// doubleword compare of the load offset against all buffered stores and the incoming one
function automatic logic exp_match(input logic [INDEX_W-1:0] off, input logic vld,
                                   input logic [ADDR_W-1:0] addr);
    logic              hit;
    logic [ADDR_W-1:0] a;
    hit = vld && (addr[INDEX_W-1:CMP_LSB] == off[INDEX_W-1:CMP_LSB]);
    foreach (spec_q[i]) begin
        a   = entry_addr(spec_q[i]);
        hit = hit || (a[INDEX_W-1:CMP_LSB] == off[INDEX_W-1:CMP_LSB]);
    end
    foreach (commit_q[i]) begin
        a   = entry_addr(commit_q[i]);
        hit = hit || (a[INDEX_W-1:CMP_LSB] == off[INDEX_W-1:CMP_LSB]);
    end
    return hit;
endfunction

task automatic compare_outputs(input logic com, input logic [INDEX_W-1:0] off, input logic vld,
                               input logic [ADDR_W-1:0] addr);
    logic [ENTRY_W-1:0] head;
    logic [ADDR_W-1:0]  head_addr;
    check_value("ready_o", 64'(ready_o), 64'(exp_ready(com)));
    check_value("commit_ready_o", 64'(commit_ready_o), 64'(commit_q.size() < COMMIT_DEPTH));
    check_value("no_st_pending_o", 64'(no_st_pending_o), 64'(commit_q.size() == 0));
    check_value("data_req_o", 64'(data_req_o), 64'(commit_q.size() != 0));
    check_value("page_offset_matches_o", 64'(page_offset_matches_o),
                64'(exp_match(off, vld, addr)));
    // the request always shows the oldest committed store, split into tag and index
    if (commit_q.size() != 0) begin
        head      = commit_q[0];
        head_addr = entry_addr(head);
        check_value("address_index_o", 64'(address_index_o), 64'(head_addr[INDEX_W-1:0]));
        check_value("address_tag_o", 64'(address_tag_o),
                    64'(head_addr[INDEX_W+TAG_W-1:INDEX_W]));
        check_value("data_wdata_o", data_wdata_o, head[DATA_W+BE_W+SIZE_W-1 -: DATA_W]);
        check_value("data_be_o", 64'(data_be_o), 64'(head[BE_W+SIZE_W-1 -: BE_W]));
        check_value("data_size_o", 64'(data_size_o), 64'(head[SIZE_W-1:0]));
    end
endtask

`endif

//--- testbench/tb_store_buffer.sv
// store buffer testbench with clock, reset, random stimulus, model checks and the test sequence

`timescale 1ns/1ps

module tb_store_buffer
    import store_buffer_pkg::*;
();

    localparam int SPEC_DEPTH   = 4;
    localparam int COMMIT_DEPTH = 4;
    // four random tests of at most 400 cycles each, plus margin
    localparam int MAX_CYCLES   = 2000;

    logic               clk_i;
    logic               rst_ni;
    logic               flush_i;
    logic [INDEX_W-1:0] page_offset_i;
    logic               commit_i;
    logic               valid_i;
    logic [ADDR_W-1:0]  paddr_i;
    logic [DATA_W-1:0]  data_i;
    logic [BE_W-1:0]    be_i;
    logic [SIZE_W-1:0]  data_size_i;
    logic               data_gnt_i;
    logic               no_st_pending_o;
    logic               page_offset_matches_o;
    logic               commit_ready_o;
    logic               ready_o;
    logic [INDEX_W-1:0] address_index_o;
    logic [TAG_W-1:0]   address_tag_o;
    logic [DATA_W-1:0]  data_wdata_o;
    logic               data_req_o;
    logic [BE_W-1:0]    data_be_o;
    logic [SIZE_W-1:0]  data_size_o;

    logic [31:0] lcg_state;
    int          check_cnt;
    int          err_cnt;
    int          test_err_start;
    int          cycle_cnt;
    // squeeze store offsets into a few doublewords so that loads hit often
    logic        narrow_addr;
    logic        gnt_level;
    int          hold_cycles;

    store_buffer #(
        .DEPTH_SPEC            (SPEC_DEPTH),
        .DEPTH_COMMIT          (COMMIT_DEPTH)
    ) i_dut (
        .clk_i                 (clk_i),
        .rst_ni                (rst_ni),
        .flush_i               (flush_i),
        .no_st_pending_o       (no_st_pending_o),
        .page_offset_i         (page_offset_i),
        .page_offset_matches_o (page_offset_matches_o),
        .commit_i              (commit_i),
        .commit_ready_o        (commit_ready_o),
        .ready_o               (ready_o),
        .valid_i               (valid_i),
        .paddr_i               (paddr_i),
        .data_i                (data_i),
        .be_i                  (be_i),
        .data_size_i           (data_size_i),
        .address_index_o       (address_index_o),
        .address_tag_o         (address_tag_o),
        .data_wdata_o          (data_wdata_o),
        .data_req_o            (data_req_o),
        .data_be_o             (data_be_o),
        .data_size_o           (data_size_o),
        .data_gnt_i            (data_gnt_i)
    );

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    // ------------------------------
    // helpers
    // ------------------------------
    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // true in roughly pct out of 100 calls
    // the low LCG bits have short periods and are skipped
    function automatic logic chance(input int pct);
        return ((next_rand() >> 8) % 100) < pct;
    endfunction

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        check_cnt++;
        if (actual !== expected) begin
            err_cnt++;
            $display("FAIL time %0t: %s is %0h, expected %0h", $time, name, actual, expected);
        end
    endtask

`include "tb_store_model.svh"

    // load offset is random, the incoming store, or a buffered store with random byte bits
    function automatic logic [INDEX_W-1:0] pick_offset(input logic [ADDR_W-1:0] addr);
        logic [31:0]       r;
        logic [ADDR_W-1:0] a;
        r = next_rand();
        a = {r, next_rand()};
        case (r[25:24])
            2'd1: a = addr;
            2'd2: if (spec_q.size() > 0) a = entry_addr(spec_q[r % spec_q.size()]);
            2'd3: if (commit_q.size() > 0) a = entry_addr(commit_q[r % commit_q.size()]);
            default: ;
        endcase
        a[CMP_LSB-1:0] = r[CMP_LSB-1:0];
        return a[INDEX_W-1:0];
    endfunction

    // drive on the falling edge, check mid cycle, then let the model take the rising edge
    task automatic run_cycle(input logic push, input logic com, input logic fl, input logic gnt);
        logic [31:0]        r;
        logic [ADDR_W-1:0]  addr;
        logic [DATA_W-1:0]  data;
        logic [ENTRY_W-1:0] entry;
        @(negedge clk_i);
        r    = next_rand();
        addr = {next_rand(), next_rand()};
        data = {next_rand(), next_rand()};
        if (narrow_addr) begin
            addr[INDEX_W-1:CMP_LSB+3] = '0;
            addr[CMP_LSB+2:CMP_LSB]   = r[2:0];
        end
        entry         = {addr, data, r[BE_W+7:8], r[SIZE_W+19:20]};
        valid_i       = push;
        paddr_i       = addr;
        data_i        = data;
        be_i          = r[BE_W+7:8];
        data_size_i   = r[SIZE_W+19:20];
        commit_i      = com;
        flush_i       = fl;
        data_gnt_i    = gnt;
        page_offset_i = pick_offset(addr);
        #10;
        compare_outputs(com, page_offset_i, push, addr);
        // a request that the cache grants here leaves the DUT at the coming edge
        if (data_req_o && gnt) begin
            retired_cnt++;
        end
        @(posedge clk_i);
        model_edge(push, com, fl, gnt, entry);
    endtask

    // legal random request mix where flush and commit never come together
    task automatic random_cycle(input int push_pct, input int com_pct, input int flush_pct,
                                input logic gnt);
        logic fl;
        logic com;
        logic push;
        fl   = chance(flush_pct);
        com  = !fl && spec_q.size() > 0 && commit_q.size() < COMMIT_DEPTH && chance(com_pct);
        push = exp_ready(com) && chance(push_pct);
        run_cycle(push, com, fl, gnt);
    endtask

    // commit and retire whatever is left so that the next test starts empty
    task automatic drain();
        while (spec_q.size() > 0 || commit_q.size() > 0) begin
            random_cycle(0, 100, 0, 1'b1);
        end
        check_value("retired store count", 64'(retired_cnt), 64'(committed_cnt));
    endtask

    task automatic finish_test(input string name);
        $display("test %s done, %0d mismatches", name, err_cnt - test_err_start);
        test_err_start = err_cnt;
    endtask

    always @(posedge clk_i) begin
        cycle_cnt++;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
            $display("test failed");
            $finish;
        end
    end

    // ------------------------------
    // test sequence
    // ------------------------------
    initial begin
        lcg_state      = 32'hcfd9_a3da;
        check_cnt      = 0;
        err_cnt        = 0;
        test_err_start = 0;
        cycle_cnt      = 0;
        narrow_addr    = 1'b0;
        gnt_level      = 1'b0;
        hold_cycles    = 0;
        rst_ni         = 1'b0;
        flush_i        = 1'b0;
        page_offset_i  = '0;
        commit_i       = 1'b0;
        valid_i        = 1'b0;
        paddr_i        = '0;
        data_i         = '0;
        be_i           = '0;
        data_size_i    = '0;
        data_gnt_i     = 1'b0;
        model_reset();
        repeat (5) @(posedge clk_i);
        @(negedge clk_i);
        rst_ni = 1'b1;

        // fixed reset values of the outputs, then one idle cycle against the model
        check_value("data_req_o", 64'(data_req_o), 64'd0);
        check_value("no_st_pending_o", 64'(no_st_pending_o), 64'd1);
        check_value("ready_o", 64'(ready_o), 64'd1);
        check_value("commit_ready_o", 64'(commit_ready_o), 64'd1);
        check_value("page_offset_matches_o", 64'(page_offset_matches_o), 64'd0);
        run_cycle(1'b0, 1'b0, 1'b0, 1'b0);
        finish_test("1 reset values");

        repeat (300) random_cycle(60, 50, 0, 1'b1);
        drain();
        finish_test("2 in-order drain");

        // the grant toggles in stretches of 1 to 12 cycles so that the commit queue fills
        repeat (300) begin
            if (hold_cycles == 0) begin
                gnt_level   = !gnt_level;
                hold_cycles = 1 + int'(next_rand() % 12);
            end
            hold_cycles--;
            random_cycle(70, 60, 0, gnt_level);
        end
        drain();
        finish_test("3 back-pressure");

        repeat (300) random_cycle(60, 40, 10, chance(50));
        drain();
        finish_test("4 flush");

        narrow_addr = 1'b1;
        repeat (300) random_cycle(50, 40, 5, chance(50));
        drain();
        finish_test("5 offset match");

        $display("summary: %0d checks, %0d mismatches", check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

//--- design/store_buffer.sv
// store buffer top level with the speculative queue, commit queue and offset checker

`timescale 1ns/1ps

module store_buffer
    import store_buffer_pkg::*;
#(
    parameter int unsigned DEPTH_SPEC   = 4,
    parameter int unsigned DEPTH_COMMIT = 4
) (
    input  logic               clk_i,
    input  logic               rst_ni,
    input  logic               flush_i,
    output logic               no_st_pending_o,
    // load path
    input  logic [INDEX_W-1:0] page_offset_i,
    output logic               page_offset_matches_o,
    // commit stage
    input  logic               commit_i,
    output logic               commit_ready_o,
    // LSU store port
    output logic               ready_o,
    input  logic               valid_i,
    input  logic [ADDR_W-1:0]  paddr_i,
    input  logic [DATA_W-1:0]  data_i,
    input  logic [BE_W-1:0]    be_i,
    input  logic [SIZE_W-1:0]  data_size_i,
    // data cache write port
    output logic [INDEX_W-1:0] address_index_o,
    output logic [TAG_W-1:0]   address_tag_o,
    output logic [DATA_W-1:0]  data_wdata_o,
    output logic               data_req_o,
    output logic [BE_W-1:0]    data_be_o,
    output logic [SIZE_W-1:0]  data_size_o,
    input  logic               data_gnt_i
);

    // ------------------------------
    // speculative to commit handoff
    // ------------------------------
    logic [ADDR_W-1:0] spec_head_addr;
    logic [DATA_W-1:0] spec_head_data;
    logic [BE_W-1:0]   spec_head_be;
    logic [SIZE_W-1:0] spec_head_size;

    // entry state seen by the offset checker
    logic [DEPTH_SPEC-1:0][INDEX_W-1:CMP_LSB]   spec_offset;
    logic [DEPTH_SPEC-1:0]                     spec_valid;
    logic [DEPTH_COMMIT-1:0][INDEX_W-1:CMP_LSB] commit_offset;
    logic [DEPTH_COMMIT-1:0]                   commit_valid;

    spec_store_queue #(
        .DEPTH_SPEC     (DEPTH_SPEC)
    ) i_spec_store_queue (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .flush_i        (flush_i),
        .valid_i        (valid_i),
        .commit_i       (commit_i),
        .paddr_i        (paddr_i),
        .data_i         (data_i),
        .be_i           (be_i),
        .size_i         (data_size_i),
        .ready_o        (ready_o),
        .head_addr_o    (spec_head_addr),
        .head_data_o    (spec_head_data),
        .head_be_o      (spec_head_be),
        .head_size_o    (spec_head_size),
        .entry_offset_o (spec_offset),
        .entry_valid_o  (spec_valid)
    );

    commit_store_queue #(
        .DEPTH_COMMIT    (DEPTH_COMMIT)
    ) i_commit_store_queue (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .commit_i        (commit_i),
        .in_addr_i       (spec_head_addr),
        .in_data_i       (spec_head_data),
        .in_be_i         (spec_head_be),
        .in_size_i       (spec_head_size),
        .data_gnt_i      (data_gnt_i),
        .commit_ready_o  (commit_ready_o),
        .no_st_pending_o (no_st_pending_o),
        .address_index_o (address_index_o),
        .address_tag_o   (address_tag_o),
        .data_wdata_o    (data_wdata_o),
        .data_be_o       (data_be_o),
        .data_size_o     (data_size_o),
        .data_req_o      (data_req_o),
        .entry_offset_o  (commit_offset),
        .entry_valid_o   (commit_valid)
    );

    page_offset_checker #(
        .DEPTH_SPEC            (DEPTH_SPEC),
        .DEPTH_COMMIT          (DEPTH_COMMIT)
    ) i_page_offset_checker (
        .page_offset_i         (page_offset_i),
        .spec_offset_i         (spec_offset),
        .spec_valid_i          (spec_valid),
        .commit_offset_i       (commit_offset),
        .commit_valid_i        (commit_valid),
        .in_addr_i             (paddr_i),
        .valid_i               (valid_i),
        .page_offset_matches_o (page_offset_matches_o)
    );

endmodule

//--- design/page_offset_checker.sv
// load page offset compare against buffered stores and the incoming store

`timescale 1ns/1ps

module page_offset_checker
    import store_buffer_pkg::*;
#(
    parameter int unsigned DEPTH_SPEC   = 4,
    parameter int unsigned DEPTH_COMMIT = 4
) (
    input  logic [INDEX_W-1:0]                        page_offset_i,
    input  logic [DEPTH_SPEC-1:0][INDEX_W-1:CMP_LSB]   spec_offset_i,
    input  logic [DEPTH_SPEC-1:0]                     spec_valid_i,
    input  logic [DEPTH_COMMIT-1:0][INDEX_W-1:CMP_LSB] commit_offset_i,
    input  logic [DEPTH_COMMIT-1:0]                   commit_valid_i,
    input  logic [ADDR_W-1:0]                         in_addr_i,
    input  logic                                      valid_i,
    output logic                                      page_offset_matches_o
);

    // page offsets are the same virtually and physically, so no translation is needed
    logic [INDEX_W-1:CMP_LSB] load_offset;
    logic [DEPTH_SPEC-1:0]    spec_hit;
    logic [DEPTH_COMMIT-1:0]  commit_hit;
    logic                     in_hit;

    assign load_offset = page_offset_i[INDEX_W-1:CMP_LSB];

    // only valid slots count, stale payload in a free slot must not stall a load
    always_comb begin
        for (int unsigned i = 0; i < DEPTH_SPEC; i++) begin
            spec_hit[i] = spec_valid_i[i] && (spec_offset_i[i] == load_offset);
        end
        for (int unsigned i = 0; i < DEPTH_COMMIT; i++) begin
            commit_hit[i] = commit_valid_i[i] && (commit_offset_i[i] == load_offset);
        end
    end

    // the store being written this cycle is not in either queue yet
    assign in_hit = valid_i && (in_addr_i[INDEX_W-1:CMP_LSB] == load_offset);

    assign page_offset_matches_o = (|spec_hit) || (|commit_hit) || in_hit;

endmodule

//--- design/commit_store_queue.sv
// non-speculative store FIFO that takes committed stores and issues them to the data cache

`timescale 1ns/1ps

module commit_store_queue
    import store_buffer_pkg::*;
#(
    parameter int unsigned DEPTH_COMMIT = 4
) (
    input  logic                                      clk_i,
    input  logic                                      rst_ni,
    input  logic                                      commit_i,
    input  logic [ADDR_W-1:0]                         in_addr_i,
    input  logic [DATA_W-1:0]                         in_data_i,
    input  logic [BE_W-1:0]                           in_be_i,
    input  logic [SIZE_W-1:0]                         in_size_i,
    input  logic                                      data_gnt_i,
    output logic                                      commit_ready_o,
    output logic                                      no_st_pending_o,
    output logic [INDEX_W-1:0]                        address_index_o,
    output logic [TAG_W-1:0]                          address_tag_o,
    output logic [DATA_W-1:0]                         data_wdata_o,
    output logic [BE_W-1:0]                           data_be_o,
    output logic [SIZE_W-1:0]                         data_size_o,
    output logic                                      data_req_o,
    output logic [DEPTH_COMMIT-1:0][INDEX_W-1:CMP_LSB] entry_offset_o,
    output logic [DEPTH_COMMIT-1:0]                   entry_valid_o
);

    localparam int unsigned PTR_W = $clog2(DEPTH_COMMIT);
    localparam int unsigned CNT_W = PTR_W + 1;

    logic [ADDR_W-1:0] addr_q [DEPTH_COMMIT];
    logic [DATA_W-1:0] data_q [DEPTH_COMMIT];
    logic [BE_W-1:0]   be_q   [DEPTH_COMMIT];
    logic [SIZE_W-1:0] size_q [DEPTH_COMMIT];

    logic [DEPTH_COMMIT-1:0] valid_q, valid_d;
    logic [PTR_W-1:0]        rd_ptr_q, rd_ptr_d;
    logic [PTR_W-1:0]        wr_ptr_q, wr_ptr_d;
    logic [CNT_W-1:0]        cnt_q, cnt_d;

    // head address seen through the tag and index view
    store_addr_u head_addr;
    // the head retires at the edge where the cache grants it
    logic        retire;

    // ------------------------------
    // cache request
    // ------------------------------
    assign data_req_o = valid_q[rd_ptr_q];
    assign retire     = data_req_o && data_gnt_i;

    // all request fields come straight from the head slot and hold until it retires
    assign head_addr.raw   = addr_q[rd_ptr_q];
    assign address_index_o = head_addr.fields.index;
    assign address_tag_o   = head_addr.fields.tag;
    assign data_wdata_o    = data_q[rd_ptr_q];
    assign data_be_o       = be_q[rd_ptr_q];
    assign data_size_o     = size_q[rd_ptr_q];

    assign commit_ready_o  = cnt_q < CNT_W'(DEPTH_COMMIT);
    // nothing left to write once the queue is empty
    assign no_st_pending_o = cnt_q == '0;

    // ------------------------------
    // next state
    // ------------------------------
    // there is no flush here, every entry is already architectural
    always_comb begin
        valid_d  = valid_q;
        rd_ptr_d = rd_ptr_q;
        wr_ptr_d = wr_ptr_q;
        cnt_d    = cnt_q;

        if (retire) begin
            valid_d[rd_ptr_q] = 1'b0;
            rd_ptr_d          = rd_ptr_q + 1'b1;
        end
        if (commit_i) begin
            valid_d[wr_ptr_q] = 1'b1;
            wr_ptr_d          = wr_ptr_q + 1'b1;
        end

        case ({commit_i, retire})
            2'b10:   cnt_d = cnt_q + 1'b1;
            2'b01:   cnt_d = cnt_q - 1'b1;
            default: cnt_d = cnt_q;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q  <= '0;
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            cnt_q    <= '0;
        end else begin
            valid_q  <= valid_d;
            rd_ptr_q <= rd_ptr_d;
            wr_ptr_q <= wr_ptr_d;
            cnt_q    <= cnt_d;
        end
    end

    // the committed store arrives from the speculative head in the same cycle
    always_ff @(posedge clk_i) begin
        if (commit_i) begin
            addr_q[wr_ptr_q] <= in_addr_i;
            data_q[wr_ptr_q] <= in_data_i;
            be_q[wr_ptr_q]   <= in_be_i;
            size_q[wr_ptr_q] <= in_size_i;
        end
    end

    always_comb begin
        for (int unsigned i = 0; i < DEPTH_COMMIT; i++) begin
            entry_offset_o[i] = addr_q[i][INDEX_W-1:CMP_LSB];
        end
    end

    assign entry_valid_o = valid_q;

endmodule

//--- design/spec_store_queue.sv
// speculative store FIFO with push, commit pop, flush and per-entry valid flags

`timescale 1ns/1ps

module spec_store_queue
    import store_buffer_pkg::*;
#(
    parameter int unsigned DEPTH_SPEC = 4
) (
    input  logic                                    clk_i,
    input  logic                                    rst_ni,
    input  logic                                    flush_i,
    input  logic                                    valid_i,
    input  logic                                    commit_i,
    input  store_addr_u                             paddr_i,
    input  logic [DATA_W-1:0]                       data_i,
    input  logic [BE_W-1:0]                         be_i,
    input  logic [SIZE_W-1:0]                       size_i,
    output logic                                    ready_o,
    output logic [ADDR_W-1:0]                       head_addr_o,
    output logic [DATA_W-1:0]                       head_data_o,
    output logic [BE_W-1:0]                         head_be_o,
    output logic [SIZE_W-1:0]                       head_size_o,
    output logic [DEPTH_SPEC-1:0][INDEX_W-1:CMP_LSB] entry_offset_o,
    output logic [DEPTH_SPEC-1:0]                   entry_valid_o
);

    localparam int unsigned PTR_W = $clog2(DEPTH_SPEC);
    // one extra bit so that a completely full queue can be counted
    localparam int unsigned CNT_W = PTR_W + 1;

    // entry payload, written on push and read at the head by the commit queue
    logic [ADDR_W-1:0] addr_q [DEPTH_SPEC];
    logic [DATA_W-1:0] data_q [DEPTH_SPEC];
    logic [BE_W-1:0]   be_q   [DEPTH_SPEC];
    logic [SIZE_W-1:0] size_q [DEPTH_SPEC];

    logic [DEPTH_SPEC-1:0] valid_q, valid_d;
    logic [PTR_W-1:0]      rd_ptr_q, rd_ptr_d;
    logic [PTR_W-1:0]      wr_ptr_q, wr_ptr_d;
    logic [CNT_W-1:0]      cnt_q, cnt_d;

    // keep one slot of slack unless the head leaves in this very cycle
    assign ready_o = (cnt_q < CNT_W'(DEPTH_SPEC - 1)) || commit_i;

    // ------------------------------
    // next state
    // ------------------------------
    always_comb begin
        valid_d  = valid_q;
        rd_ptr_d = rd_ptr_q;
        wr_ptr_d = wr_ptr_q;
        cnt_d    = cnt_q;

        // the head moves over to the commit queue, so drop its flag first
        // a push into the same slot of a full queue then wins
        if (commit_i) begin
            valid_d[rd_ptr_q] = 1'b0;
            rd_ptr_d          = rd_ptr_q + 1'b1;
        end
        if (valid_i) begin
            valid_d[wr_ptr_q] = 1'b1;
            wr_ptr_d          = wr_ptr_q + 1'b1;
        end

        case ({valid_i, commit_i})
            2'b10:   cnt_d = cnt_q + 1'b1;
            2'b01:   cnt_d = cnt_q - 1'b1;
            default: cnt_d = cnt_q;
        endcase

        // a flush throws away every speculative store, including one pushed now
        // the read pointer stays where it is since nothing was committed
        if (flush_i) begin
            valid_d  = '0;
            wr_ptr_d = rd_ptr_q;
            cnt_d    = '0;
        end
    end

    // ------------------------------
    // registers
    // ------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q  <= '0;
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            cnt_q    <= '0;
        end else begin
            valid_q  <= valid_d;
            rd_ptr_q <= rd_ptr_d;
            wr_ptr_q <= wr_ptr_d;
            cnt_q    <= cnt_d;
        end
    end

    // payload is only meaningful where the matching valid flag is set
    always_ff @(posedge clk_i) begin
        if (valid_i) begin
            addr_q[wr_ptr_q] <= paddr_i.raw;
            data_q[wr_ptr_q] <= data_i;
            be_q[wr_ptr_q]   <= be_i;
            size_q[wr_ptr_q] <= size_i;
        end
    end

    // the oldest store, taken by the commit queue on commit_i
    assign head_addr_o = addr_q[rd_ptr_q];
    assign head_data_o = data_q[rd_ptr_q];
    assign head_be_o   = be_q[rd_ptr_q];
    assign head_size_o = size_q[rd_ptr_q];

    // doubleword offsets of all slots for the load address check
    always_comb begin
        for (int unsigned i = 0; i < DEPTH_SPEC; i++) begin
            entry_offset_o[i] = addr_q[i][INDEX_W-1:CMP_LSB];
        end
    end

    assign entry_valid_o = valid_q;

endmodule

//--- design/store_buffer_pkg.sv
// store buffer widths, compare boundary and the store address union

package store_buffer_pkg;

    // ------------------------------
    // widths
    // ------------------------------

    // physical address width, one full word
    parameter int unsigned ADDR_W  = 64;
    // store data width and its byte enables
    parameter int unsigned DATA_W  = 64;
    parameter int unsigned BE_W    = 8;
    // encoded access size (byte, half, word, double)
    parameter int unsigned SIZE_W  = 2;
    // the cache index is the page offset, identical in virtual and physical space
    parameter int unsigned INDEX_W = 12;
    // the tag covers the physical page number bits that the cache keeps
    parameter int unsigned TAG_W   = 44;
    // loads and stores are matched per doubleword, so the byte lane bits are ignored
    parameter int unsigned CMP_LSB = 3;

    // ------------------------------
    // store address
    // ------------------------------

    // the queues hold the raw word, the cache port wants it split into tag and index
    // the upper bits above the tag are not used by the cache
    typedef union packed {
        logic [ADDR_W-1:0] raw;
        struct packed {
            logic [ADDR_W-TAG_W-INDEX_W-1:0] unused;
            logic [TAG_W-1:0]                tag;
            logic [INDEX_W-1:0]              index;
        } fields;
    } store_addr_u;

endpackage
